//--- tb_tile_host.sv
/*
  Testbench of the tile host block: clock, reset, APB driver tasks,
  xorshift stimulus, L2 model, concurrent checks and report
*/
module tb_tile_host
  import tile_host_pkg::*;
;

  localparam int unsigned       L2_WORDS   = 256;
  localparam int unsigned       FIFO_DEPTH = 4;
  localparam logic [DATA_W-1:0] BOOT_RESET = 32'h0000_0080;
  localparam int unsigned       TIMEOUT    = 50;

  logic clk;
  logic rst_n_i;
  apb_req_t apb_req;
  apb_rsp_t apb_rsp;
  logic char_valid_o;
  logic [7:0] char_o;
  logic char_ready_i;
  logic [DATA_W-1:0] boot_addr_o;
  logic fetch_enable_o;
  logic eoc_o;
  logic [30:0] exit_code_o;
  logic [7:0] err_count_o;

  // Expected state, kept from the address map and register rules
  logic [DATA_W-1:0] exp_boot;
  logic exp_fetch;
  logic exp_eoc;
  logic [30:0] exp_exit;
  logic [7:0] exp_errcnt;
  logic exp_err;
  logic chk_rdata;
  logic [DATA_W-1:0] exp_rdata;
  int unsigned wait_min;
  int unsigned wait_max;
  int unsigned wait_cnt;
  logic cmp_en;
  string cmp_name;
  logic [63:0] cmp_exp;
  logic [63:0] cmp_act;
  logic [7:0] char_exp [16];
  int unsigned n_in;
  int unsigned n_out;
  logic [DATA_W-1:0] model [L2_WORDS];
  int unsigned ofs [32];
  logic [31:0] rng_state;
  int errors;
  int tests;
  int prev_errors;
  logic done;
  logic [DATA_W-1:0] rd;
  logic [DATA_W-1:0] lo;
  logic [DATA_W-1:0] hi;
  logic [DATA_W-1:0] v;
  logic [63:0] t1;
  logic [63:0] t2;

  tile_host_top #(
    .L2_WORDS   ( L2_WORDS   ),
    .FIFO_DEPTH ( FIFO_DEPTH ),
    .BOOT_RESET ( BOOT_RESET )
  ) i_dut (
    .clk            ( clk            ),
    .rst_n_i        ( rst_n_i        ),
    .apb_req_i      ( apb_req        ),
    .apb_rsp_o      ( apb_rsp        ),
    .char_valid_o   ( char_valid_o   ),
    .char_o         ( char_o         ),
    .char_ready_i   ( char_ready_i   ),
    .boot_addr_o    ( boot_addr_o    ),
    .fetch_enable_o ( fetch_enable_o ),
    .eoc_o          ( eoc_o          ),
    .exit_code_o    ( exit_code_o    ),
    .err_count_o    ( err_count_o    )
  );

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  assign done = apb_req.psel && apb_req.penable && apb_rsp.pready;

  // Wait states of the running access, cleared outside the access phase
  always_ff @(posedge clk or negedge rst_n_i) begin
    if (!rst_n_i) begin
      wait_cnt <= 0;
    end else if (apb_req.psel && apb_req.penable && !apb_rsp.pready) begin
      wait_cnt <= wait_cnt + 1;
    end else begin
      wait_cnt <= 0;
    end
  end

  // Characters leaving the FIFO
  always_ff @(posedge clk or negedge rst_n_i) begin
    if (!rst_n_i) n_out <= 0;
    else if (char_valid_o && char_ready_i) n_out <= n_out + 1;
  end

  a_pslverr: assert property (@(posedge clk) disable iff (!rst_n_i)
    done |-> (apb_rsp.pslverr == exp_err))
    else begin
      errors++;
      $display("CHECK FAILED %0t pslverr expected %0b actual %0b",
               $time, exp_err, $sampled(apb_rsp.pslverr));
    end
  a_prdata: assert property (@(posedge clk) disable iff (!rst_n_i)
    (done && !apb_req.pwrite && chk_rdata) |-> (apb_rsp.prdata == exp_rdata))
    else begin
      errors++;
      $display("CHECK FAILED %0t prdata expected %h actual %h",
               $time, exp_rdata, $sampled(apb_rsp.prdata));
    end
  a_waits: assert property (@(posedge clk) disable iff (!rst_n_i)
    done |-> (wait_cnt >= wait_min) && (wait_cnt <= wait_max))
    else begin
      errors++;
      $display("CHECK FAILED %0t wait states expected %0d..%0d actual %0d",
               $time, wait_min, wait_max, $sampled(wait_cnt));
    end
  a_boot: assert property (@(posedge clk) disable iff (!rst_n_i) boot_addr_o == exp_boot)
    else begin
      errors++;
      $display("CHECK FAILED %0t boot_addr_o expected %h actual %h",
               $time, exp_boot, $sampled(boot_addr_o));
    end
  a_fetch: assert property (@(posedge clk) disable iff (!rst_n_i) fetch_enable_o == exp_fetch)
    else begin
      errors++;
      $display("CHECK FAILED %0t fetch_enable_o expected %0b actual %0b",
               $time, exp_fetch, $sampled(fetch_enable_o));
    end
  a_eoc: assert property (@(posedge clk) disable iff (!rst_n_i) eoc_o == exp_eoc)
    else begin
      errors++;
      $display("CHECK FAILED %0t eoc_o expected %0b actual %0b",
               $time, exp_eoc, $sampled(eoc_o));
    end
  a_exit: assert property (@(posedge clk) disable iff (!rst_n_i) exit_code_o == exp_exit)
    else begin
      errors++;
      $display("CHECK FAILED %0t exit_code_o expected %h actual %h",
               $time, exp_exit, $sampled(exit_code_o));
    end
  a_errcnt: assert property (@(posedge clk) disable iff (!rst_n_i) err_count_o == exp_errcnt)
    else begin
      errors++;
      $display("CHECK FAILED %0t err_count_o expected %h actual %h",
               $time, exp_errcnt, $sampled(err_count_o));
    end
  // Characters must leave in write order
  a_char_order: assert property (@(posedge clk) disable iff (!rst_n_i)
    (char_valid_o && char_ready_i) |-> (char_o == char_exp[n_out]))
    else begin
      errors++;
      $display("CHECK FAILED %0t char_o expected %h actual %h",
               $time, char_exp[$sampled(n_out)], $sampled(char_o));
    end
  a_compare: assert property (@(posedge clk) disable iff (!rst_n_i)
    cmp_en |-> (cmp_act == cmp_exp))
    else begin
      errors++;
      $display("CHECK FAILED %0t %s expected %h actual %h", $time, cmp_name, cmp_exp, cmp_act);
    end

  function automatic logic [31:0] xorshift32();
    logic [31:0] x;
    x = rng_state;
    x ^= x << 13;
    x ^= x >> 17;
    x ^= x << 5;
    rng_state = x;
    return x;
  endfunction

  task automatic abort(input string what);
    $display("%s at time %0t", what, $time);
    $display("Simulation failed");
    $finish;
  endtask

  task automatic expect_resp(input logic err, input int unsigned wmin, input int unsigned wmax);
    exp_err  = err;
    wait_min = wmin;
    wait_max = wmax;
  endtask

  // One APB transfer, pready sampled at the falling edge
  task automatic apb_xfer(input logic wr, input logic [ADDR_W-1:0] addr,
                          input logic [DATA_W-1:0] wdata, output logic [DATA_W-1:0] rdata);
    int unsigned n;
    @(posedge clk);
    #1;
    apb_req = '{psel: 1'b1, penable: 1'b0, pwrite: wr, paddr: addr, pwdata: wdata};
    @(posedge clk);
    #1;
    apb_req.penable = 1'b1;
    n = 0;
    @(negedge clk);
    while (!apb_rsp.pready) begin
      n++;
      if (n > TIMEOUT) abort("No pready from the DUT");
      @(negedge clk);
    end
    rdata = apb_rsp.prdata;
    @(posedge clk);
    #1;
    apb_req = '0;
  endtask

  task automatic apb_write(input logic [ADDR_W-1:0] addr, input logic [DATA_W-1:0] data);
    logic [DATA_W-1:0] unused;
    chk_rdata = 1'b0;
    apb_xfer(1'b1, addr, data, unused);
  endtask

  task automatic apb_read(input logic [ADDR_W-1:0] addr, input logic chk,
                          input logic [DATA_W-1:0] exp, output logic [DATA_W-1:0] data);
    chk_rdata = chk;
    exp_rdata = exp;
    apb_xfer(1'b0, addr, '0, data);
  endtask

  // Hands a value pair to a_compare for one clock
  task automatic compare(input string name, input logic [63:0] exp, input logic [63:0] act);
    cmp_name = name;
    cmp_exp  = exp;
    cmp_act  = act;
    cmp_en   = 1'b1;
    @(posedge clk);
    #1;
    cmp_en = 1'b0;
  endtask

  task automatic end_test(input string name);
    tests++;
    $display("test %0d %s: %s", tests, name, (errors == prev_errors) ? "ok" : "errors");
    prev_errors = errors;
  endtask

  initial begin
    rst_n_i = 1'b0;
    apb_req = '0;
    char_ready_i = 1'b0;
    exp_boot = BOOT_RESET;
    exp_fetch = 1'b0;
    exp_eoc = 1'b0;
    exp_exit = '0;
    exp_errcnt = '0;
    chk_rdata = 1'b0;
    exp_rdata = '0;
    cmp_en = 1'b0;
    cmp_name = "";
    cmp_exp = '0;
    cmp_act = '0;
    n_in = 0;
    rng_state = 32'd24;
    errors = 0;
    tests = 0;
    prev_errors = 0;
    expect_resp(1'b0, 0, 0);
    repeat (5) @(posedge clk);
    #1;
    rst_n_i = 1'b1;

    // L2 writes at random offsets, then read back with one wait state
    for (int i = 0; i < 32; i++) begin
      ofs[i] = xorshift32() % L2_WORDS;
      v = xorshift32();
      model[ofs[i]] = v;
      apb_write(ADDR_W'(ofs[i] * 4), v);
    end
    expect_resp(1'b0, 1, 1);
    for (int i = 0; i < 32; i++) apb_read(ADDR_W'(ofs[i] * 4), 1'b1, model[ofs[i]], rd);
    end_test("L2 round trip");

    // Boot address starts at its reset value
    expect_resp(1'b0, 0, 0);
    apb_read(BOOT_ADDR_OFS, 1'b1, BOOT_RESET, rd);
    v = xorshift32();
    apb_write(BOOT_ADDR_OFS, v);
    exp_boot = v;
    apb_read(BOOT_ADDR_OFS, 1'b1, v, rd);
    apb_write(FETCH_EN_OFS, 32'd1);
    exp_fetch = 1'b1;
    apb_read(FETCH_EN_OFS, 1'b1, 32'd1, rd);
    end_test("control registers");

    // Low half first so the high half comes from the shadow
    apb_read(TIMER_LO_OFS, 1'b0, '0, lo);
    apb_read(TIMER_HI_OFS, 1'b0, '0, hi);
    t1 = {hi, lo};
    apb_read(TIMER_LO_OFS, 1'b0, '0, lo);
    apb_read(TIMER_HI_OFS, 1'b0, '0, hi);
    t2 = {hi, lo};
    compare("timer increase", 64'd1, 64'(t2 > t1));
    apb_write(FETCH_EN_OFS, 32'd0);
    exp_fetch = 1'b0;
    apb_read(TIMER_LO_OFS, 1'b0, '0, lo);
    apb_read(TIMER_HI_OFS, 1'b0, '0, hi);
    t1 = {hi, lo};
    apb_read(TIMER_LO_OFS, 1'b0, '0, lo);
    apb_read(TIMER_HI_OFS, 1'b0, '0, hi);
    t2 = {hi, lo};
    compare("timer hold", t1, t2);
    expect_resp(1'b1, 0, 0);
    apb_write(TIMER_LO_OFS, 32'h1234);
    end_test("timer");

    // Fill the FIFO with the sink stalled
    expect_resp(1'b0, 0, 0);
    for (int i = 0; i < FIFO_DEPTH; i++) begin
      v = xorshift32();
      char_exp[n_in] = v[7:0];
      n_in++;
      apb_write(STDOUT_OFS, v);
    end
    apb_read(STDOUT_OFS, 1'b1, FIFO_DEPTH, rd);
    v = xorshift32();
    char_exp[n_in] = v[7:0];
    n_in++;
    expect_resp(1'b0, 5, TIMEOUT);
    fork
      apb_write(STDOUT_OFS, v);
      begin
        repeat (8) @(posedge clk);
        #1;
        char_ready_i = 1'b1;
      end
    join
    // Sink open, wait until the FIFO runs empty
    for (int n = 0; char_valid_o; n++) begin
      if (n > TIMEOUT) abort("Characters did not drain from the FIFO");
      @(posedge clk);
      #1;
    end
    compare("characters out", n_in, n_out);
    expect_resp(1'b0, 0, 0);
    apb_read(STDOUT_OFS, 1'b1, 32'd0, rd);
    end_test("stdout back-pressure");

    v = xorshift32();
    apb_write(STDERR_OFS, v);
    exp_errcnt = v[7:0];
    apb_read(STDERR_OFS, 1'b1, {24'd0, v[7:0]}, rd);
    v = xorshift32() | 32'h8000_0000;
    apb_write(EOC_OFS, v);
    exp_eoc = 1'b1;
    exp_exit = v[30:0];
    // Status checks see the new EOC value on the next edge
    @(posedge clk);
    #1;
    end_test("end of computation");

    // Word 0 is where 16'h3000 would land in the L2 if the decode leaked
    v = xorshift32();
    model[0] = v;
    apb_write(L2_BASE_OFS, v);
    expect_resp(1'b1, 0, 0);
    apb_write(16'h3000, 32'hdead_beef);
    apb_read(16'h3000, 1'b0, '0, rd);
    expect_resp(1'b0, 1, 1);
    apb_read(L2_BASE_OFS, 1'b1, model[0], rd);
    end_test("decode errors");

    repeat (2) @(posedge clk);
    $display("tests %0d errors %0d", tests, errors);
    if (errors == 0) begin
      $display("Simulation passed");
    end else begin
      $display("Simulation failed");
    end
    $finish;
  end

endmodule

//--- tile_cycle_timer.sv
/*
  64-bit cycle counter gated by fetch enable, high-half shadow
*/
module tile_cycle_timer
  import tile_host_pkg::*;
(
  input  logic     clk,
  input  logic     rst_n_i,
  input  tgt_req_t req_i,
  output tgt_rsp_t rsp_o,
  input  logic     enable_i
);

  // Word index of the high half, low half sits at zero
  localparam logic [ADDR_W-1:0] HI_IDX = (TIMER_HI_OFS - TIMER_LO_OFS) >> 2;

  logic [63:0] count_q;
  logic [31:0] shadow_q;
  logic        rd_lo;

  assign rd_lo = req_i.valid && !req_i.write && (req_i.offset != HI_IDX);

  // Counts every clock while the core is enabled
  always_ff @(posedge clk or negedge rst_n_i) begin
    if (!rst_n_i) begin
      count_q <= '0;
    end else if (enable_i) begin
      count_q <= count_q + 64'd1;
    end
  end

  // Upper half frozen on a low read so the pair reads consistently
  always_ff @(posedge clk or negedge rst_n_i) begin
    if (!rst_n_i) begin
      shadow_q <= '0;
    end else if (rd_lo) begin
      shadow_q <= count_q[63:32];
    end
  end

  // Always ready
  assign rsp_o.ready = 1'b1;
  assign rsp_o.rdata = (req_i.offset == HI_IDX) ? shadow_q : count_q[31:0];

endmodule

//--- tile_host_ctrl.sv
/*
  APB slave FSM, address decoder, boot/fetch/EOC registers
  and response mux over the datapath targets
*/
module tile_host_ctrl
  import tile_host_pkg::*;
#(
  parameter int unsigned       L2_WORDS   = 256,
  parameter logic [DATA_W-1:0] BOOT_RESET = 32'h0000_0080
) (
  input  logic              clk,
  input  logic              rst_n_i,
  input  apb_req_t          apb_req_i,
  output apb_rsp_t          apb_rsp_o,
  output tgt_req_t          l2_req_o,
  output tgt_req_t          timer_req_o,
  output tgt_req_t          print_req_o,
  input  tgt_rsp_t          l2_rsp_i,
  input  tgt_rsp_t          timer_rsp_i,
  input  tgt_rsp_t          print_rsp_i,
  output logic [DATA_W-1:0] boot_addr_o,
  output logic              fetch_enable_o,
  output logic              eoc_o,
  output logic [30:0]       exit_code_o
);

  apb_state_e        state_q;
  tgt_e              tgt;
  logic              acc;
  logic              err;
  logic              rdy;
  logic [DATA_W-1:0] rdata;
  logic [DATA_W-1:0] reg_rdata;
  logic [ADDR_W-1:0] l2_ofs;
  logic [ADDR_W-1:0] timer_ofs;
  logic [ADDR_W-1:0] print_ofs;

  // Word offsets relative to each datapath base
  assign l2_ofs    = (apb_req_i.paddr - L2_BASE_OFS) >> 2;
  assign timer_ofs = (apb_req_i.paddr - TIMER_LO_OFS) >> 2;
  assign print_ofs = (apb_req_i.paddr - STDERR_OFS) >> 2;

  // Address decode, L2 window sized by L2_WORDS
  always_comb begin
    case (apb_req_i.paddr)
      BOOT_ADDR_OFS, FETCH_EN_OFS, EOC_OFS: tgt = TGT_REG;
      TIMER_LO_OFS, TIMER_HI_OFS:           tgt = TGT_TIMER;
      STDERR_OFS, STDOUT_OFS:               tgt = TGT_PRINT;
      default: tgt = (l2_ofs < L2_WORDS) ? TGT_L2 : TGT_NONE;
    endcase
  end

  // Access phase and rejected accesses
  assign acc = (state_q == ACCESS) && apb_req_i.psel && apb_req_i.penable;
  assign err = (tgt == TGT_NONE) || ((tgt == TGT_TIMER) && apb_req_i.pwrite);

  always_ff @(posedge clk or negedge rst_n_i) begin
    if (!rst_n_i) begin
      state_q <= IDLE;
    end else begin
      case (state_q)
        // Setup phase seen, move on to access
        IDLE: if (apb_req_i.psel && !apb_req_i.penable) state_q <= ACCESS;
        ACCESS: if (!apb_req_i.psel || apb_rsp_o.pready) state_q <= IDLE;
        default: state_q <= IDLE;
      endcase
    end
  end

  // Only one target sees valid, never on a rejected access
  assign l2_req_o    = '{valid: acc && (tgt == TGT_L2), write: apb_req_i.pwrite,
                         offset: l2_ofs, wdata: apb_req_i.pwdata};
  assign timer_req_o = '{valid: acc && (tgt == TGT_TIMER) && !err, write: apb_req_i.pwrite,
                         offset: timer_ofs, wdata: apb_req_i.pwdata};
  assign print_req_o = '{valid: acc && (tgt == TGT_PRINT), write: apb_req_i.pwrite,
                         offset: print_ofs, wdata: apb_req_i.pwdata};

  // Local registers, written on the edge ending the access
  always_ff @(posedge clk or negedge rst_n_i) begin
    if (!rst_n_i) begin
      boot_addr_o    <= BOOT_RESET;
      fetch_enable_o <= 1'b0;
      eoc_o          <= 1'b0;
      exit_code_o    <= '0;
    end else if (acc && apb_req_i.pwrite && (tgt == TGT_REG)) begin
      case (apb_req_i.paddr)
        BOOT_ADDR_OFS: boot_addr_o <= apb_req_i.pwdata;
        FETCH_EN_OFS:  fetch_enable_o <= apb_req_i.pwdata[0];
        EOC_OFS: begin
          eoc_o       <= apb_req_i.pwdata[31];
          exit_code_o <= apb_req_i.pwdata[30:0];
        end
        default: ;
      endcase
    end
  end

  always_comb begin
    case (apb_req_i.paddr)
      BOOT_ADDR_OFS: reg_rdata = boot_addr_o;
      FETCH_EN_OFS:  reg_rdata = {{(DATA_W-1){1'b0}}, fetch_enable_o};
      EOC_OFS:       reg_rdata = {eoc_o, exit_code_o};
      default:       reg_rdata = '0;
    endcase
  end

  // Response mux from the selected target
  always_comb begin
    rdy   = 1'b1;
    rdata = '0;
    case (tgt)
      TGT_L2: begin
        rdy   = l2_rsp_i.ready;
        rdata = l2_rsp_i.rdata;
      end
      TGT_TIMER: begin
        rdy   = timer_rsp_i.ready;
        rdata = timer_rsp_i.rdata;
      end
      TGT_PRINT: begin
        rdy   = print_rsp_i.ready;
        rdata = print_rsp_i.rdata;
      end
      TGT_REG: rdata = reg_rdata;
      default: ;
    endcase
  end

  assign apb_rsp_o.pready  = acc && (err || rdy);
  assign apb_rsp_o.prdata  = rdata;
  assign apb_rsp_o.pslverr = acc && err;

  // APB master behaviour seen at this slave
  a_penable_psel: assert property (@(posedge clk) disable iff (!rst_n_i)
    apb_req_i.penable |-> apb_req_i.psel);
  a_wait_stable: assert property (@(posedge clk) disable iff (!rst_n_i)
    (acc && !apb_rsp_o.pready) |=> $stable(apb_req_i.paddr) && $stable(apb_req_i.pwrite));

endmodule

//--- tile_host_pkg.sv
/*
  Shared definitions of the tile host block: widths, APB address map,
  decode target and APB state enums, APB and target structs
*/
package tile_host_pkg;

  // Bus widths
  localparam int unsigned ADDR_W = 16;
  localparam int unsigned DATA_W = 32;

  // Address map, byte addresses on the APB
  localparam logic [ADDR_W-1:0] L2_BASE_OFS   = 16'h0000;
  localparam logic [ADDR_W-1:0] BOOT_ADDR_OFS = 16'h1000;
  localparam logic [ADDR_W-1:0] FETCH_EN_OFS  = 16'h1004;
  localparam logic [ADDR_W-1:0] EOC_OFS       = 16'h1008;
  localparam logic [ADDR_W-1:0] TIMER_LO_OFS  = 16'h1010;
  localparam logic [ADDR_W-1:0] TIMER_HI_OFS  = 16'h1014;
  localparam logic [ADDR_W-1:0] STDERR_OFS    = 16'h2000;
  localparam logic [ADDR_W-1:0] STDOUT_OFS    = 16'h2004;

  // Decode targets
  typedef enum logic [2:0] {
    TGT_L2,
    TGT_REG,
    TGT_TIMER,
    TGT_PRINT,
    TGT_NONE
  } tgt_e;

  // APB slave states
  typedef enum logic {
    IDLE,
    ACCESS
  } apb_state_e;

  typedef struct packed {
    logic              psel;
    logic              penable;
    logic              pwrite;
    logic [ADDR_W-1:0] paddr;
    logic [DATA_W-1:0] pwdata;
  } apb_req_t;

  typedef struct packed {
    logic              pready;
    logic [DATA_W-1:0] prdata;
    logic              pslverr;
  } apb_rsp_t;

  // Request to one datapath, offset counted in words from its base
  typedef struct packed {
    logic              valid;
    logic              write;
    logic [ADDR_W-1:0] offset;
    logic [DATA_W-1:0] wdata;
  } tgt_req_t;

  typedef struct packed {
    logic              ready;
    logic [DATA_W-1:0] rdata;
  } tgt_rsp_t;

endpackage

//--- tile_host_top.sv
/*
  Top level of the tile host block: control module, L2 memory,
  print unit and cycle timer
*/
module tile_host_top
  import tile_host_pkg::*;
#(
  parameter int unsigned       L2_WORDS   = 256,
  parameter int unsigned       FIFO_DEPTH = 4,
  parameter logic [DATA_W-1:0] BOOT_RESET = 32'h0000_0080
) (
  input  logic              clk,
  input  logic              rst_n_i,
  input  apb_req_t          apb_req_i,
  output apb_rsp_t          apb_rsp_o,
  output logic              char_valid_o,
  output logic [7:0]        char_o,
  input  logic              char_ready_i,
  output logic [DATA_W-1:0] boot_addr_o,
  output logic              fetch_enable_o,
  output logic              eoc_o,
  output logic [30:0]       exit_code_o,
  output logic [7:0]        err_count_o
);

  tgt_req_t l2_req;
  tgt_req_t timer_req;
  tgt_req_t print_req;
  tgt_rsp_t l2_rsp;
  tgt_rsp_t timer_rsp;
  tgt_rsp_t print_rsp;

  // APB decode and local registers
  tile_host_ctrl #(
    .L2_WORDS   ( L2_WORDS   ),
    .BOOT_RESET ( BOOT_RESET )
  ) i_ctrl (
    .clk            ( clk            ),
    .rst_n_i        ( rst_n_i        ),
    .apb_req_i      ( apb_req_i      ),
    .apb_rsp_o      ( apb_rsp_o      ),
    .l2_req_o       ( l2_req         ),
    .timer_req_o    ( timer_req      ),
    .print_req_o    ( print_req      ),
    .l2_rsp_i       ( l2_rsp         ),
    .timer_rsp_i    ( timer_rsp      ),
    .print_rsp_i    ( print_rsp      ),
    .boot_addr_o    ( boot_addr_o    ),
    .fetch_enable_o ( fetch_enable_o ),
    .eoc_o          ( eoc_o          ),
    .exit_code_o    ( exit_code_o    )
  );

  tile_l2_mem #(
    .L2_WORDS ( L2_WORDS )
  ) i_l2_mem (
    .clk     ( clk     ),
    .rst_n_i ( rst_n_i ),
    .req_i   ( l2_req  ),
    .rsp_o   ( l2_rsp  )
  );

  tile_print_unit #(
    .FIFO_DEPTH ( FIFO_DEPTH )
  ) i_print (
    .clk          ( clk          ),
    .rst_n_i      ( rst_n_i      ),
    .req_i        ( print_req    ),
    .rsp_o        ( print_rsp    ),
    .char_valid_o ( char_valid_o ),
    .char_o       ( char_o       ),
    .char_ready_i ( char_ready_i ),
    .err_count_o  ( err_count_o  )
  );

  // Timer runs only while fetch is enabled
  tile_cycle_timer i_timer (
    .clk      ( clk            ),
    .rst_n_i  ( rst_n_i        ),
    .req_i    ( timer_req      ),
    .rsp_o    ( timer_rsp      ),
    .enable_i ( fetch_enable_o )
  );

endmodule

//--- tile_l2_mem.sv
/*
  L2 scratch memory of L2_WORDS words, one wait state on reads
*/
module tile_l2_mem
  import tile_host_pkg::*;
#(
  parameter int unsigned L2_WORDS = 256
) (
  input  logic     clk,
  input  logic     rst_n_i,
  input  tgt_req_t req_i,
  output tgt_rsp_t rsp_o
);

  localparam int unsigned IDX_W = (L2_WORDS > 1) ? $clog2(L2_WORDS) : 1;

  logic [DATA_W-1:0] mem [L2_WORDS];
  logic [DATA_W-1:0] rdata_q;
  logic              pending_q;
  logic [IDX_W-1:0]  idx;

  assign idx = req_i.offset[IDX_W-1:0];

  // Write on the access cycle, read data registered
  always_ff @(posedge clk) begin
    if (req_i.valid && req_i.write) begin
      mem[idx] <= req_i.wdata;
    end
    if (req_i.valid && !req_i.write && !pending_q) begin
      rdata_q <= mem[idx];
    end
  end

  // Pending read completes in the APB wait state, then clears
  always_ff @(posedge clk or negedge rst_n_i) begin
    if (!rst_n_i) begin
      pending_q <= 1'b0;
    end else begin
      pending_q <= req_i.valid && !req_i.write && !pending_q;
    end
  end

  assign rsp_o.ready = req_i.write ? 1'b1 : pending_q;
  assign rsp_o.rdata = rdata_q;

  // The decoder keeps every access inside the array
  a_offset_range: assert property (@(posedge clk) disable iff (!rst_n_i)
    req_i.valid |-> (req_i.offset < L2_WORDS));

endmodule

//--- tile_print_unit.sv
/*
  Stdout character FIFO with back-pressure, stderr error-count register
*/
module tile_print_unit
  import tile_host_pkg::*;
#(
  parameter int unsigned FIFO_DEPTH = 4
) (
  input  logic       clk,
  input  logic       rst_n_i,
  input  tgt_req_t   req_i,
  output tgt_rsp_t   rsp_o,
  output logic       char_valid_o,
  output logic [7:0] char_o,
  input  logic       char_ready_i,
  output logic [7:0] err_count_o
);

  localparam int unsigned PTR_W = (FIFO_DEPTH > 1) ? $clog2(FIFO_DEPTH) : 1;
  localparam int unsigned CNT_W = $clog2(FIFO_DEPTH + 1);
  // Word index of stdout inside this unit, stderr sits at zero
  localparam logic [ADDR_W-1:0] OUT_IDX = (STDOUT_OFS - STDERR_OFS) >> 2;

  logic [7:0]       fifo [FIFO_DEPTH];
  logic [PTR_W-1:0] wr_ptr_q;
  logic [PTR_W-1:0] rd_ptr_q;
  logic [CNT_W-1:0] count_q;
  logic             is_out;
  logic             full;
  logic             push;
  logic             pop;

  assign is_out = (req_i.offset == OUT_IDX);
  assign full   = (count_q == CNT_W'(FIFO_DEPTH));
  assign push   = req_i.valid && req_i.write && is_out && !full;
  assign pop    = char_valid_o && char_ready_i;

  always_ff @(posedge clk) begin
    if (push) fifo[wr_ptr_q] <= req_i.wdata[7:0];
  end

  // Circular pointers and fill level
  always_ff @(posedge clk or negedge rst_n_i) begin
    if (!rst_n_i) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
    end else begin
      if (push) wr_ptr_q <= (wr_ptr_q == PTR_W'(FIFO_DEPTH - 1)) ? '0 : wr_ptr_q + 1'b1;
      if (pop)  rd_ptr_q <= (rd_ptr_q == PTR_W'(FIFO_DEPTH - 1)) ? '0 : rd_ptr_q + 1'b1;
      if (push && !pop)      count_q <= count_q + 1'b1;
      else if (pop && !push) count_q <= count_q - 1'b1;
    end
  end

  // Error count from the low byte of a stderr write
  always_ff @(posedge clk or negedge rst_n_i) begin
    if (!rst_n_i) begin
      err_count_o <= '0;
    end else if (req_i.valid && req_i.write && !is_out) begin
      err_count_o <= req_i.wdata[7:0];
    end
  end

  assign char_valid_o = (count_q != '0);
  assign char_o       = fifo[rd_ptr_q];

  // Stall a stdout write while full, reads return level or error count
  assign rsp_o.ready = !(req_i.write && is_out && full);
  assign rsp_o.rdata = is_out ? DATA_W'(count_q) : DATA_W'(err_count_o);

  // Full means the write pointer has wrapped onto the oldest character
  a_no_push_full: assert property (@(posedge clk) disable iff (!rst_n_i)
    full |-> (wr_ptr_q == rd_ptr_q));
  a_char_stable: assert property (@(posedge clk) disable iff (!rst_n_i)
    (char_valid_o && !char_ready_i) |=> char_valid_o && $stable(char_o));

endmodule

//--- verilog.f
tile_host_pkg.sv
tile_host_ctrl.sv
tile_l2_mem.sv
tile_print_unit.sv
tile_cycle_timer.sv
tile_host_top.sv
tb_tile_host.sv
